// File: design/filterPkg.sv
`default_nettype none

package filterPkg;

    // Modulator and downsampling geometry
    localparam int M = 2;
    localparam int DSR = 4;
    localparam int WORD_BITS = M * DSR;
    localparam int LOOKAHEAD = 16;
    localparam int HIST_WORDS = LOOKAHEAD / DSR;
    localparam int AHEAD_BITS = M * LOOKAHEAD;

    // Input bits handled by one LUT
    localparam int LUT_SIZE = 4;

    // Fixed-point widths
    localparam int COEF_WIDTH = 16;
    localparam int AHEAD_SUM_WIDTH = 22;
    localparam int BACK_SUM_WIDTH = 19;
    localparam int STATE_WIDTH = 24;
    localparam int OUT_WIDTH = 12;
    localparam int OUT_SHIFT = 8;

    // One-pole feedback, 0.75 with 15 fraction bits
    localparam logic signed [COEF_WIDTH-1:0] POLE_COEF = 16'sd24576;
    localparam int POLE_SHIFT = 15;

    // Lookahead taps, bit pairs per sample (LSB weight, then MSB weight)
    localparam logic signed [COEF_WIDTH-1:0] aheadCoef [AHEAD_BITS] = '{
        -16'sd360,  -16'sd720,   16'sd1020,  16'sd2040,
         16'sd2160,  16'sd4320,  16'sd3750,  16'sd7500,
         16'sd5700,  16'sd11400, 16'sd7800,  16'sd15600,
         16'sd9600,  16'sd19200, 16'sd10650, 16'sd21300,
         16'sd10650, 16'sd21300, 16'sd9600,  16'sd19200,
         16'sd7800,  16'sd15600, 16'sd5700,  16'sd11400,
         16'sd3750,  16'sd7500,  16'sd2160,  16'sd4320,
         16'sd1020,  16'sd2040, -16'sd360,  -16'sd720
    };

    // Lookback taps over the oldest word
    localparam logic signed [COEF_WIDTH-1:0] backCoef [WORD_BITS] = '{
        16'sd3000, 16'sd6000, 16'sd5000, 16'sd10000,
        16'sd7000, 16'sd14000, 16'sd9000, 16'sd18000
    };

    // Path latencies in clkDS cycles
    localparam int AHEAD_LATENCY = 4;
    localparam int BACK_LATENCY = 3;
    localparam int ALIGN_DELAY = AHEAD_LATENCY - BACK_LATENCY;

    typedef struct packed {
        logic valid;
        // Oldest sample sits in the lowest bits
        logic [AHEAD_BITS-1:0] window;
        logic [WORD_BITS-1:0] backWord;
    } historyT;

    typedef struct packed {
        logic valid;
        logic signed [AHEAD_SUM_WIDTH-1:0] sum;
    } aheadResultT;

    typedef struct packed {
        logic valid;
        logic signed [STATE_WIDTH-1:0] state;
    } backResultT;

    typedef struct packed {
        logic outValid;
        logic [OUT_WIDTH-1:0] out;
    } filterOutT;

endpackage

`default_nettype wire

// File: design/sampleHistory.sv
`default_nettype none

module sampleHistory (
    input  logic                           clkDS,
    input  logic                           rstN,
    input  logic                           sampleValid,
    input  logic [filterPkg::WORD_BITS-1:0] sampleWord,
    output filterPkg::historyT             histOut
);
    import filterPkg::*;

    localparam int FILL_WIDTH = $clog2(HIST_WORDS + 1);

    // Entry 0 holds the newest word
    logic [WORD_BITS-1:0] words [HIST_WORDS];
    logic [FILL_WIDTH-1:0] fillCount;
    logic histValid;
    logic [AHEAD_BITS-1:0] window;

    // Word storage shifts only on accepted words
    always_ff @(posedge clkDS) begin
        if (sampleValid) begin
            words[0] <= sampleWord;
            for (int i = 1; i < HIST_WORDS; i++) begin
                words[i] <= words[i-1];
            end
        end
    end

    // Fill tracking, saturates once the window is complete
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            fillCount <= '0;
            histValid <= 1'b0;
        end else begin
            // The current word counts toward the fill
            histValid <= sampleValid && (fillCount >= FILL_WIDTH'(HIST_WORDS - 1));
            if (sampleValid && (fillCount != FILL_WIDTH'(HIST_WORDS))) begin
                fillCount <= fillCount + 1'b1;
            end
        end
    end

    // Oldest word goes to the lowest window bits
    always_comb begin
        for (int i = 0; i < HIST_WORDS; i++) begin
            window[WORD_BITS*i +: WORD_BITS] = words[HIST_WORDS-1-i];
        end
    end

    // Lookback path works on the oldest word
    assign histOut = '{
        valid:    histValid,
        window:   window,
        backWord: words[HIST_WORDS-1]
    };

endmodule

`default_nettype wire

// File: design/lutDotProduct.sv
`default_nettype none

module lutDotProduct #(
    parameter int NBITS = 8,
    parameter int SUM_WIDTH = 19,
    parameter logic signed [filterPkg::COEF_WIDTH-1:0] COEFS [NBITS] = '{default: '0}
) (
    input  logic                        clkDS,
    input  logic                        rstN,
    input  logic                        selValid,
    input  logic [NBITS-1:0]            sel,
    output logic                        sumValid,
    output logic signed [SUM_WIDTH-1:0] sum
);
    import filterPkg::*;

    localparam int NGROUPS = (NBITS + LUT_SIZE - 1) / LUT_SIZE;
    localparam int LUT_ENTRIES = 2 ** LUT_SIZE;
    localparam int LEVELS = $clog2(NGROUPS);
    localparam int TREE_WIDTH = 2 ** LEVELS;

    // Sum of coefficients for the set bits of one pattern
    function automatic logic signed [SUM_WIDTH-1:0] groupSum(input int group, input int pattern);
        logic signed [SUM_WIDTH-1:0] acc;
        int idx;
        acc = '0;
        for (int b = 0; b < LUT_SIZE; b++) begin
            idx = group * LUT_SIZE + b;
            if (pattern[b] && (idx < NBITS)) begin
                acc = acc + COEFS[idx];
            end
        end
        return acc;
    endfunction

    logic [NGROUPS*LUT_SIZE-1:0] selPad;
    logic signed [SUM_WIDTH-1:0] lutRom [NGROUPS][LUT_ENTRIES];
    logic signed [SUM_WIDTH-1:0] lutOut [TREE_WIDTH];
    logic signed [SUM_WIDTH-1:0] tree [LEVELS+1][TREE_WIDTH];
    logic [LEVELS:0] validPipe;

    // Zero-fill a partial last group
    assign selPad = (NGROUPS * LUT_SIZE)'(sel);

    // Constant tables, one per group
    for (genvar g = 0; g < NGROUPS; g++) begin : g_group
        for (genvar p = 0; p < LUT_ENTRIES; p++) begin : g_entry
            assign lutRom[g][p] = groupSum(g, p);
        end
        assign lutOut[g] = lutRom[g][selPad[g*LUT_SIZE +: LUT_SIZE]];
    end

    // Unused leaves of the tree add nothing
    for (genvar g = NGROUPS; g < TREE_WIDTH; g++) begin : g_pad
        assign lutOut[g] = '0;
    end

    // LUT register followed by one register per adder level
    always_ff @(posedge clkDS) begin
        for (int g = 0; g < TREE_WIDTH; g++) begin
            tree[0][g] <= lutOut[g];
        end
        for (int l = 0; l < LEVELS; l++) begin
            for (int n = 0; n < (TREE_WIDTH >> (l + 1)); n++) begin
                tree[l+1][n] <= tree[l][2*n] + tree[l][2*n+1];
            end
        end
    end

    // Valid bit tracks the data stage by stage
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= selValid;
            for (int l = 0; l < LEVELS; l++) begin
                validPipe[l+1] <= validPipe[l];
            end
        end
    end

    assign sum = tree[LEVELS][0];
    assign sumValid = validPipe[LEVELS];

endmodule

`default_nettype wire

// File: design/lookbackRecursion.sv
`default_nettype none

module lookbackRecursion (
    input  logic                                     clkDS,
    input  logic                                     rstN,
    input  logic                                     termValid,
    input  logic signed [filterPkg::BACK_SUM_WIDTH-1:0] term,
    output filterPkg::backResultT                    backOut
);
    import filterPkg::*;

    logic signed [STATE_WIDTH-1:0] state;
    logic signed [STATE_WIDTH+COEF_WIDTH-1:0] product;
    logic signed [STATE_WIDTH-1:0] decayed;
    logic signed [STATE_WIDTH-1:0] nextState;
    logic stateValid;

    // Pole multiply, then drop the fraction bits
    assign product = state * POLE_COEF;
    assign decayed = product[POLE_SHIFT +: STATE_WIDTH];

    // Term is sign-extended to the state width
    assign nextState = decayed + term;

    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            state <= '0;
            stateValid <= 1'b0;
        end else begin
            stateValid <= termValid;
            // State holds between accepted words
            if (termValid) begin
                state <= nextState;
            end
        end
    end

    assign backOut = '{valid: stateValid, state: state};

endmodule

`default_nettype wire

// File: design/outputCombiner.sv
`default_nettype none

module outputCombiner (
    input  logic                   clkDS,
    input  logic                   rstN,
    input  filterPkg::aheadResultT aheadIn,
    input  filterPkg::backResultT  backIn,
    output filterPkg::filterOutT   filterOut
);
    import filterPkg::*;

    localparam int FULL_WIDTH =
        ((AHEAD_SUM_WIDTH > STATE_WIDTH) ? AHEAD_SUM_WIDTH : STATE_WIDTH) + 1;
    localparam logic signed [FULL_WIDTH-1:0] SAT_HI = (2 ** (OUT_WIDTH - 1)) - 1;
    localparam logic signed [FULL_WIDTH-1:0] SAT_LO = -(2 ** (OUT_WIDTH - 1));

    logic [ALIGN_DELAY-1:0] validDelay;
    logic signed [STATE_WIDTH-1:0] stateDelay [ALIGN_DELAY];
    backResultT backAligned;
    logic signed [FULL_WIDTH-1:0] sumFull;
    logic signed [FULL_WIDTH-1:0] sumShifted;
    logic signed [OUT_WIDTH-1:0] saturated;

    // Lookback path is shorter, hold it back to match
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            validDelay <= '0;
        end else begin
            validDelay[0] <= backIn.valid;
            for (int i = 1; i < ALIGN_DELAY; i++) begin
                validDelay[i] <= validDelay[i-1];
            end
        end
    end

    always_ff @(posedge clkDS) begin
        stateDelay[0] <= backIn.state;
        for (int i = 1; i < ALIGN_DELAY; i++) begin
            stateDelay[i] <= stateDelay[i-1];
        end
    end

    assign backAligned = '{valid: validDelay[ALIGN_DELAY-1], state: stateDelay[ALIGN_DELAY-1]};

    assign sumFull = aheadIn.sum + backAligned.state;
    assign sumShifted = sumFull >>> OUT_SHIFT;

    // Clamp to the signed output range
    always_comb begin
        if (sumShifted > SAT_HI) begin
            saturated = SAT_HI[OUT_WIDTH-1:0];
        end else if (sumShifted < SAT_LO) begin
            saturated = SAT_LO[OUT_WIDTH-1:0];
        end else begin
            saturated = sumShifted[OUT_WIDTH-1:0];
        end
    end

    // Flipping the sign bit gives offset binary
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            filterOut <= '0;
        end else begin
            filterOut.outValid <= aheadIn.valid;
            filterOut.out <= {~saturated[OUT_WIDTH-1], saturated[OUT_WIDTH-2:0]};
        end
    end

endmodule

`default_nettype wire

// File: design/hybridFilterTop.sv
`default_nettype none

module hybridFilterTop (
    input  logic                            clkDS,
    input  logic                            rstN,
    input  logic                            sampleValid,
    input  logic [filterPkg::WORD_BITS-1:0] sampleWord,
    output logic                            outValid,
    output logic [filterPkg::OUT_WIDTH-1:0] out
);
    import filterPkg::*;

    historyT histOut;
    aheadResultT aheadResult;
    logic backSumValid;
    logic signed [BACK_SUM_WIDTH-1:0] backSum;
    backResultT backResult;
    filterOutT filterOut;

    // Word history, window and lookback word
    sampleHistory i_history (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sampleWord  (sampleWord),
        .histOut     (histOut)
    );

    // Lookahead FIR term over the full window
    lutDotProduct #(
        .NBITS     (AHEAD_BITS),
        .SUM_WIDTH (AHEAD_SUM_WIDTH),
        .COEFS     (aheadCoef)
    ) i_aheadDot (
        .clkDS    (clkDS),
        .rstN     (rstN),
        .selValid (histOut.valid),
        .sel      (histOut.window),
        .sumValid (aheadResult.valid),
        .sum      (aheadResult.sum)
    );

    // Lookback input term from the oldest word
    lutDotProduct #(
        .NBITS     (WORD_BITS),
        .SUM_WIDTH (BACK_SUM_WIDTH),
        .COEFS     (backCoef)
    ) i_backDot (
        .clkDS    (clkDS),
        .rstN     (rstN),
        .selValid (histOut.valid),
        .sel      (histOut.backWord),
        .sumValid (backSumValid),
        .sum      (backSum)
    );

    // IIR part
    lookbackRecursion i_recursion (
        .clkDS     (clkDS),
        .rstN      (rstN),
        .termValid (backSumValid),
        .term      (backSum),
        .backOut   (backResult)
    );

    outputCombiner i_combiner (
        .clkDS     (clkDS),
        .rstN      (rstN),
        .aheadIn   (aheadResult),
        .backIn    (backResult),
        .filterOut (filterOut)
    );

    assign outValid = filterOut.outValid;
    assign out = filterOut.out;

endmodule

`default_nettype wire

// File: sim/hybridFilter_sva.sv
`default_nettype none

module hybridFilterSva (
    input logic clkDS,
    input logic rstN,
    input logic sampleValid,
    input logic outValid,
    input logic aheadValid,
    input logic backValid
);
    import filterPkg::*;

    // Acceptance edge to the edge that samples outValid high
    localparam int OUT_DELAY = 6;

    logic [3:0] acceptCount;
    logic fullAccept;

    // Saturating count of accepted words since reset
    always_ff @(posedge clkDS or negedge rstN) begin
        if (!rstN) begin
            acceptCount <= '0;
        end else if (sampleValid && (acceptCount != 4'(HIST_WORDS))) begin
            acceptCount <= acceptCount + 4'd1;
        end
    end

    // Word that completes or extends a full history
    assign fullAccept = sampleValid && (acceptCount >= 4'(HIST_WORDS - 1));

    resetQuiet: assert property (@(posedge clkDS) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    outTiming: assert property (@(posedge clkDS) disable iff (!rstN)
        outValid == $past(fullAccept, OUT_DELAY))
        else $error("outValid does not follow an accepted word by %0d edges", OUT_DELAY);

    // Aligned lookback valid in the combiner must match lookahead valid
    alignedValids: assert property (@(posedge clkDS) disable iff (!rstN)
        aheadValid == backValid)
        else $error("aligned valid bits in the combiner disagree");

endmodule

bind hybridFilterTop hybridFilterSva i_sva (
    .clkDS       (clkDS),
    .rstN        (rstN),
    .sampleValid (sampleValid),
    .outValid    (outValid),
    .aheadValid  (aheadResult.valid),
    .backValid   (i_combiner.backAligned.valid)
);

`default_nettype wire

// File: sim/hybridFilterTb.sv
`default_nettype none

module hybridFilterTb;
    import filterPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int SPARSE_CYCLES = 100;
    localparam int RANDOM_CYCLES = 1500;
    localparam int ZERO_CYCLES = 100;
    localparam int ONES_CYCLES = 100;
    localparam int BURST_CYCLES = 100;
    localparam int TAIL_CYCLES = 100;
    localparam int STIM_CYCLES = SPARSE_CYCLES + RANDOM_CYCLES + ZERO_CYCLES
                               + ONES_CYCLES + BURST_CYCLES + TAIL_CYCLES;
    // Reset and drains fit in half the stimulus length again
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2;
    localparam int OUT_LATENCY = 6;

    localparam int WORDS_RANDOM = 0;
    localparam int WORDS_ZERO = 1;
    localparam int WORDS_ONES = 2;

    logic clkDS;
    logic rstN;
    logic sampleValid;
    logic [WORD_BITS-1:0] sampleWord;
    logic outValid;
    logic [OUT_WIDTH-1:0] out;

    integer seed;
    int errorCount;
    int outCount;
    int cycleCount;
    int burstStart;

    // Reference model state
    logic [AHEAD_BITS-1:0] modelWindow;
    int modelFill;
    longint modelState;
    logic [OUT_WIDTH-1:0] expectQ [$];
    logic [OUT_WIDTH-1:0] expected;
    logic [OUT_WIDTH-1:0] lastOut;

    hybridFilterTop i_dut (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sampleWord  (sampleWord),
        .outValid    (outValid),
        .out         (out)
    );

    always #4 clkDS = ~clkDS;

    // FIR term, one package coefficient per set window bit
    function automatic longint aheadDot(input logic [AHEAD_BITS-1:0] window);
        longint acc;
        acc = 0;
        for (int j = 0; j < AHEAD_BITS; j++) begin
            if (window[j]) begin
                acc += aheadCoef[j];
            end
        end
        return acc;
    endfunction

    function automatic longint backDot(input logic [WORD_BITS-1:0] word);
        longint acc;
        acc = 0;
        for (int j = 0; j < WORD_BITS; j++) begin
            if (word[j]) begin
                acc += backCoef[j];
            end
        end
        return acc;
    endfunction

    // Shift, clamp to the signed range, then add half scale for offset binary
    function automatic logic [OUT_WIDTH-1:0] scaleOut(input longint total);
        longint shifted;
        longint half;
        half = longint'(1) <<< (OUT_WIDTH - 1);
        shifted = total >>> OUT_SHIFT;
        if (shifted > half - 1) begin
            shifted = half - 1;
        end else if (shifted < -half) begin
            shifted = -half;
        end
        return OUT_WIDTH'(shifted + half);
    endfunction

    task automatic drivePhase(input int cycles, input int density, input int pattern);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clkDS);
            sampleValid <= ($unsigned($random(seed)) % 100) < density;
            case (pattern)
                WORDS_ZERO: sampleWord <= '0;
                WORDS_ONES: sampleWord <= '1;
                default: sampleWord <= WORD_BITS'($random(seed));
            endcase
        end
        @(posedge clkDS);
        sampleValid <= 1'b0;
    endtask

    // Wait for every pending output, then idle to catch stray pulses
    task automatic waitDrain;
        @(posedge clkDS);
        while (expectQ.size() != 0) begin
            @(posedge clkDS);
        end
        repeat (OUT_LATENCY + 2) @(posedge clkDS);
    endtask

    always @(posedge clkDS) begin
        if (!rstN) begin
            modelWindow = '0;
            modelFill = 0;
            modelState = 0;
            expectQ.delete();
        end else begin
            if (outValid) begin
                if (expectQ.size() == 0) begin
                    $display("Unexpected outValid pulse at time %0t with no output pending",
                             $time);
                    errorCount++;
                end else begin
                    expected = expectQ.pop_front();
                    outCount++;
                    lastOut = out;
                    if (out !== expected) begin
                        $display("Error at time %0t: out = %h, expected %h",
                                 $time, out, expected);
                        errorCount++;
                    end
                end
            end
            if (sampleValid) begin
                // Newest word enters at the top, oldest leaves the bottom
                modelWindow = {sampleWord, modelWindow[AHEAD_BITS-1:WORD_BITS]};
                if (modelFill < HIST_WORDS) begin
                    modelFill++;
                end
                if (modelFill == HIST_WORDS) begin
                    modelState = ((modelState * longint'(POLE_COEF)) >>> POLE_SHIFT)
                               + backDot(modelWindow[WORD_BITS-1:0]);
                    expectQ.push_back(scaleOut(aheadDot(modelWindow) + modelState));
                end
            end
        end
    end

    always @(posedge clkDS) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d outputs still pending",
                     cycleCount, expectQ.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed = 32'h7b15877d;
        clkDS = 1'b0;
        rstN = 1'b0;
        sampleValid = 1'b0;
        sampleWord = '0;
        errorCount = 0;
        outCount = 0;
        cycleCount = 0;
        lastOut = '0;
        repeat (RESET_CYCLES) @(posedge clkDS);
        rstN <= 1'b1;

        // Sparse words first so the fill sees wide gaps
        drivePhase(SPARSE_CYCLES, 25, WORDS_RANDOM);
        drivePhase(RANDOM_CYCLES, 75, WORDS_RANDOM);

        drivePhase(ZERO_CYCLES, 75, WORDS_ZERO);
        waitDrain();
        if (lastOut !== 12'h800) begin
            $display("Error at time %0t: out = %h, expected %h", $time, lastOut, 12'h800);
            errorCount++;
        end

        // Full-scale input drives the sum past the top of the range
        drivePhase(ONES_CYCLES, 75, WORDS_ONES);
        waitDrain();
        if (lastOut !== 12'hFFF) begin
            $display("Error at time %0t: out = %h, expected %h", $time, lastOut, 12'hFFF);
            errorCount++;
        end

        burstStart = outCount;
        drivePhase(BURST_CYCLES, 100, WORDS_RANDOM);
        waitDrain();
        if (outCount - burstStart != BURST_CYCLES) begin
            $display("Error at time %0t: burst output count = %0d, expected %0d",
                     $time, outCount - burstStart, BURST_CYCLES);
            errorCount++;
        end

        drivePhase(TAIL_CYCLES, 75, WORDS_RANDOM);
        waitDrain();

        if (expectQ.size() != 0) begin
            $display("%0d expected outputs were never produced", expectQ.size());
            errorCount++;
        end
        $display("Run complete with %0d errors over %0d checked outputs",
                 errorCount, outCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/filterPkg.sv
design/sampleHistory.sv
design/lutDotProduct.sv
design/lookbackRecursion.sv
design/outputCombiner.sv
design/hybridFilterTop.sv
sim/hybridFilter_sva.sv
sim/hybridFilterTb.sv

// File: Makefile
TOP := hybridFilterTb
SRCS := $(shell cat vlog.f)

obj_dir/V$(TOP): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

.PHONY: all run clean

all: obj_dir/V$(TOP)

run: obj_dir/V$(TOP)
	@result="$$(./obj_dir/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
